//--- l2c.f
source/l2c_pkg.sv
source/l2c_bram.sv
source/l2c_tag_valid.sv
source/l2c_data_array.sv
source/l2c_replace.sv
source/l2c_ctrl.sv
source/l2c_top.sv
verif/l2c_assert.sv
verif/l2c_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the L2 cache testbench with Verilator
set -e

cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert --timing \
    --top-module l2c_tb \
    --Mdir "$build_dir" \
    -o l2c_sim \
    -f l2c.f

# Keep running past assertion errors so the closing count is printed
"./$build_dir/l2c_sim" +verilator+error+limit+1000 > "$log_file" 2>&1 || true

cat "$log_file"

if grep -qF '*** TEST PASSED ***' "$log_file"; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed, see $log_file"
exit 1

//--- verif/l2c_tb.sv
`timescale 1ns/1ps

module l2c_tb;

    import l2c_pkg::*;

    localparam int set_bits       = 4;
    localparam int tag_w          = addr_w - offset_bits - set_bits;
    localparam int sets           = 2**set_bits;
    localparam int line_w         = addr_w - offset_bits;
    localparam int clk_period     = 100;
    localparam int reset_cycles   = 16;
    localparam int directed_reqs  = 21;
    localparam int random_reqs    = 300;
    localparam int timeout_cycles = (directed_reqs + random_reqs) * 200 + reset_cycles;

    logic              clk;
    logic              arst_n;
    logic              req;
    logic [addr_w-1:0] req_addr;
    logic              busy;
    logic              resp_valid;
    l2c_resp_t         resp;
    logic              mem_req;
    logic [line_w-1:0] mem_addr;
    logic              mem_rvalid;
    logic [word_w-1:0] mem_rdata;

    // Reference model, tree bits say where the next victim lies
    logic [tag_w-1:0] model_tag   [sets][ways];
    logic             model_valid [sets][ways];
    logic             tree_hi     [sets];
    logic             pick_lo     [sets];
    logic             pick_hi     [sets];

    // Outstanding responses and refills, oldest first
    l2c_resp_t         exp_q  [$];
    logic [line_w-1:0] line_q [$];
    l2c_resp_t         resp_head = '0;
    logic [line_w-1:0] line_head = '0;
    logic              resp_ok   = 1'b0;
    logic              line_ok   = 1'b0;
    logic              resp_seen = 1'b0;
    logic              mem_seen  = 1'b0;

    int data_errs  = 0;
    int hit_errs   = 0;
    int addr_errs  = 0;
    int order_errs = 0;

    l2c_top #(.set_bits(set_bits)) l2c_top_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .req_addr   (req_addr),
        .busy       (busy),
        .resp_valid (resp_valid),
        .resp       (resp),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    //////////////////////////////
    // Checks
    //////////////////////////////

    resp_order_chk: assert property (@(posedge clk) disable iff (!arst_n) resp_valid |-> resp_ok)
        else begin
            order_errs++;
            $display("Response at %0t arrived with no request outstanding", $time);
        end

    resp_data_chk: assert property (@(posedge clk) disable iff (!arst_n)
        (resp_valid && resp_ok) |-> (resp.data == resp_head.data))
        else begin
            data_errs++;
            $display("** Error at %0t: read data %h, expected %h", $time,
                     $sampled(resp.data), resp_head.data);
        end

    resp_hit_chk: assert property (@(posedge clk) disable iff (!arst_n)
        (resp_valid && resp_ok) |-> (resp.hit == resp_head.hit))
        else begin
            hit_errs++;
            $display("** Error at %0t: hit flag %b, expected %b", $time,
                     $sampled(resp.hit), resp_head.hit);
        end

    refill_order_chk: assert property (@(posedge clk) disable iff (!arst_n) mem_req |-> line_ok)
        else begin
            order_errs++;
            $display("Memory request at %0t although every access should hit", $time);
        end

    refill_addr_chk: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_req && line_ok) |-> (mem_addr == line_head))
        else begin
            addr_errs++;
            $display("** Error at %0t: mem_addr %h, expected %h", $time,
                     $sampled(mem_addr), line_head);
        end

    // Heads advance one falling edge after their strobe was sampled
    always @(negedge clk) begin
        if (resp_seen && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
        end
        if (mem_seen && line_q.size() != 0) begin
            void'(line_q.pop_front());
        end
        resp_seen = resp_valid;
        mem_seen  = mem_req;
        resp_ok   = (exp_q.size() != 0);
        line_ok   = (line_q.size() != 0);
        if (resp_ok) begin
            resp_head = exp_q[0];
        end
        if (line_ok) begin
            line_head = line_q[0];
        end
    end

    //////////////////////////////
    // Model and helpers
    //////////////////////////////

    function automatic logic [word_w-1:0] mem_word(input logic [addr_w-1:0] waddr);
        return word_w'(waddr) ^ 32'h5a5a0000;
    endfunction

    function automatic logic [addr_w-1:0] make_addr(input int tag, input int set_i, input int off);
        return {tag_w'(tag), set_bits'(set_i), offset_bits'(off)};
    endfunction

    function automatic int pick_victim(input int set_i);
        int way;
        way = -1;
        // Lowest invalid way first
        for (int w = ways - 1; w >= 0; w--) begin
            if (!model_valid[set_i][w]) begin
                way = w;
            end
        end
        if (way < 0) begin
            way = tree_hi[set_i] ? 2 + int'(pick_hi[set_i]) : int'(pick_lo[set_i]);
        end
        return way;
    endfunction

    // Steer both tree levels away from the used way
    function automatic void mark_used(input int set_i, input int way);
        if (way < 2) begin
            tree_hi[set_i] = 1'b1;
            pick_lo[set_i] = (way == 0);
        end else begin
            tree_hi[set_i] = 1'b0;
            pick_hi[set_i] = (way == 2);
        end
    endfunction

    function automatic logic predict(input logic [addr_w-1:0] addr);
        int               set_i;
        int               way;
        logic [tag_w-1:0] tag;
        logic             found;
        set_i = int'(addr[offset_bits +: set_bits]);
        tag   = addr[addr_w-1 -: tag_w];
        found = 1'b0;
        way   = 0;
        for (int w = 0; w < ways; w++) begin
            if (model_valid[set_i][w] && model_tag[set_i][w] == tag) begin
                found = 1'b1;
                way   = w;
            end
        end
        if (!found) begin
            way = pick_victim(set_i);
            model_valid[set_i][way] = 1'b1;
            model_tag[set_i][way]   = tag;
        end
        mark_used(set_i, way);
        return found;
    endfunction

    // Called on a falling edge, returns on the next one
    task automatic issue_req(input logic [addr_w-1:0] addr);
        l2c_resp_t want;
        while (busy) begin
            req = 1'b0;
            @(negedge clk);
        end
        want.hit  = predict(addr);
        want.data = mem_word(addr);
        exp_q.push_back(want);
        if (!want.hit) begin
            line_q.push_back(addr[addr_w-1:offset_bits]);
        end
        req      = 1'b1;
        req_addr = addr;
        @(negedge clk);
        req = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || busy) begin
            @(negedge clk);
        end
    endtask

    //////////////////////////////
    // Clock, memory, watchdog
    //////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Four words per refill after 1 to 6 idle cycles
    initial begin
        logic [line_w-1:0] line;
        int                delay;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        forever begin
            @(negedge clk);
            if (mem_req) begin
                line  = mem_addr;
                delay = int'($urandom % 6) + 1;
                repeat (delay - 1) @(negedge clk);
                for (int k = 0; k < 4; k++) begin
                    @(negedge clk);
                    mem_rvalid = 1'b1;
                    mem_rdata  = mem_word({line, offset_bits'(k)});
                end
                @(negedge clk);
                mem_rvalid = 1'b0;
            end
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the cache stopped answering",
                 timeout_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        int total;
        void'($urandom(32'h76dabdfb));
        arst_n   = 1'b0;
        req      = 1'b0;
        req_addr = '0;
        for (int s = 0; s < sets; s++) begin
            tree_hi[s] = 1'b0;
            pick_lo[s] = 1'b0;
            pick_hi[s] = 1'b0;
            for (int w = 0; w < ways; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w]   = '0;
            end
        end
        repeat (reset_cycles) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // Cold misses
        issue_req(make_addr(1, 0, 0));
        wait_drain();
        issue_req(make_addr(2, 1, 3));
        wait_drain();
        issue_req(make_addr(3, 7, 1));
        wait_drain();

        // Same word and same line again
        issue_req(make_addr(1, 0, 0));
        issue_req(make_addr(1, 0, 2));
        issue_req(make_addr(2, 1, 0));
        wait_drain();

        // Hits on consecutive cycles
        issue_req(make_addr(3, 7, 0));
        issue_req(make_addr(1, 0, 1));
        issue_req(make_addr(2, 1, 2));
        issue_req(make_addr(3, 7, 3));
        wait_drain();

        // Second request stalls behind a miss, same line then other line
        issue_req(make_addr(4, 0, 1));
        issue_req(make_addr(4, 0, 3));
        wait_drain();
        issue_req(make_addr(5, 1, 2));
        issue_req(make_addr(6, 1, 0));
        wait_drain();

        // Fill set 5 with A to D, E evicts A
        for (int t = 10; t < 14; t++) begin
            issue_req(make_addr(t, 5, 0));
            wait_drain();
        end
        issue_req(make_addr(14, 5, 0));
        wait_drain();
        issue_req(make_addr(10, 5, 1));
        wait_drain();
        issue_req(make_addr(13, 5, 2));
        wait_drain();

        // Random traffic over sets 2 and 3
        for (int n = 0; n < random_reqs; n++) begin
            issue_req(make_addr(int'($urandom % 6), 2 + int'($urandom % 2),
                                int'($urandom % 4)));
            if ($urandom % 3 == 0) begin
                @(negedge clk);
            end
        end
        wait_drain();
        repeat (4) @(negedge clk);

        total = data_errs + hit_errs + addr_errs + order_errs
              + l2c_top_inst.l2c_assert_inst.fail_cnt;
        $display("Errors: data %0d, hit %0d, mem_addr %0d, order %0d, protocol %0d",
                 data_errs, hit_errs, addr_errs, order_errs,
                 l2c_top_inst.l2c_assert_inst.fail_cnt);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- verif/l2c_assert.sv
`timescale 1ns/1ps

module l2c_assert (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     req,
    input logic                     busy,
    input logic                     resp_valid,
    input logic                     resp_hit,
    input logic                     mem_req,
    input logic [l2c_pkg::ways-1:0] hit
);

    // Read by the testbench for its closing count
    int fail_cnt = 0;

    // Requester holds off while the cache is busy
    no_req_busy: assert property (@(posedge clk) disable iff (!arst_n) !(req && busy))
        else begin
            fail_cnt++;
            $error("request strobe seen while busy was high");
        end

    // Accepted request that hits in compare answers two edges after it was sampled
    hit_latency: assert property (@(posedge clk) disable iff (!arst_n)
        ($past(req && !busy, 2) && (|hit) && !busy) |=> (resp_valid && resp_hit))
        else begin
            fail_cnt++;
            $error("hit did not respond two cycles after the request");
        end

    // Refill request belongs to a miss
    mem_req_busy: assert property (@(posedge clk) disable iff (!arst_n) mem_req |-> busy)
        else begin
            fail_cnt++;
            $error("memory request raised while not busy");
        end

endmodule

bind l2c_top l2c_assert l2c_assert_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .req        (req),
    .busy       (busy),
    .resp_valid (resp_valid),
    .resp_hit   (resp.hit),
    .mem_req    (mem_req),
    .hit        (hit)
);

//--- source/l2c_top.sv
`timescale 1ns/1ps

module l2c_top #(
    parameter int set_bits = 4
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       req,
    input  logic [l2c_pkg::addr_w-1:0] req_addr,
    output logic                       busy,
    output logic                       resp_valid,
    output l2c_pkg::l2c_resp_t         resp,
    output logic                       mem_req,
    output logic [l2c_pkg::addr_w-l2c_pkg::offset_bits-1:0] mem_addr,
    input  logic                       mem_rvalid,
    input  logic [l2c_pkg::word_w-1:0] mem_rdata
);

    import l2c_pkg::*;

    localparam int tag_w = addr_w - offset_bits - set_bits;

    logic [set_bits-1:0]    rd_set;
    logic [offset_bits-1:0] rd_offset;
    logic [tag_w-1:0]       cmp_tag;
    logic [ways-1:0]        hit;
    logic [ways-1:0]        valid;
    logic [word_w-1:0]      rdata;
    logic [1:0]             victim;
    l2c_fill_t              fill;
    logic                   fill_we;
    logic                   fill_last;
    logic [tag_w-1:0]       fill_tag;
    logic                   touch;
    logic [set_bits-1:0]    touch_set;
    logic [1:0]             touch_way;

    l2c_ctrl #(.set_bits(set_bits)) ctrl_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .req_addr   (req_addr),
        .busy       (busy),
        .resp_valid (resp_valid),
        .resp       (resp),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .rd_set     (rd_set),
        .rd_offset  (rd_offset),
        .cmp_tag    (cmp_tag),
        .hit        (hit),
        .rdata      (rdata),
        .victim     (victim),
        .fill       (fill),
        .fill_we    (fill_we),
        .fill_last  (fill_last),
        .fill_tag   (fill_tag),
        .touch      (touch),
        .touch_set  (touch_set),
        .touch_way  (touch_way)
    );

    l2c_tag_valid #(.set_bits(set_bits)) tag_valid_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_set    (rd_set),
        .cmp_tag   (cmp_tag),
        .fill      (fill),
        .fill_last (fill_last),
        .fill_tag  (fill_tag),
        .hit       (hit),
        .valid     (valid)
    );

    l2c_data_array #(.set_bits(set_bits)) data_array_inst (
        .clk       (clk),
        .rd_set    (rd_set),
        .rd_offset (rd_offset),
        .hit       (hit),
        .fill      (fill),
        .fill_we   (fill_we),
        .rdata     (rdata)
    );

    // Touch set is always the compare stage set
    l2c_replace #(.set_bits(set_bits)) replace_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .set       (touch_set),
        .valid     (valid),
        .touch     (touch),
        .touch_set (touch_set),
        .touch_way (touch_way),
        .victim    (victim)
    );

endmodule

//--- source/l2c_ctrl.sv
`timescale 1ns/1ps

module l2c_ctrl #(
    parameter int set_bits = 4,
    localparam int tag_w = l2c_pkg::addr_w - l2c_pkg::offset_bits - set_bits
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            req,
    input  logic [l2c_pkg::addr_w-1:0]      req_addr,
    output logic                            busy,
    output logic                            resp_valid,
    output l2c_pkg::l2c_resp_t              resp,
    output logic                            mem_req,
    output logic [l2c_pkg::addr_w-l2c_pkg::offset_bits-1:0] mem_addr,
    input  logic                            mem_rvalid,
    input  logic [l2c_pkg::word_w-1:0]      mem_rdata,
    output logic [set_bits-1:0]             rd_set,
    output logic [l2c_pkg::offset_bits-1:0] rd_offset,
    output logic [tag_w-1:0]                cmp_tag,
    input  logic [l2c_pkg::ways-1:0]        hit,
    input  logic [l2c_pkg::word_w-1:0]      rdata,
    input  logic [1:0]                      victim,
    output l2c_pkg::l2c_fill_t              fill,
    output logic                            fill_we,
    output logic                            fill_last,
    output logic [tag_w-1:0]                fill_tag,
    output logic                            touch,
    output logic [set_bits-1:0]             touch_set,
    output logic [1:0]                      touch_way
);

    import l2c_pkg::*;

    l2c_req_t               lk_q;
    l2c_req_t               cmp_q;
    l2c_state_e             state_q;
    logic [offset_bits-1:0] cnt_q;
    logic [1:0]             fill_way_q;
    logic [word_w-1:0]      miss_word_q;
    logic                   replay_q;
    logic                   hit_any;
    logic                   cmp_hit;
    logic                   miss;
    logic [1:0]             hit_way;
    logic [set_bits-1:0]    cmp_set;

    //////////////////////////////
    // Stage decode
    //////////////////////////////

    // Lookup stage addresses the RAMs
    assign rd_set    = lk_q.addr[offset_bits +: set_bits];
    assign rd_offset = lk_q.addr[offset_bits-1:0];
    assign cmp_tag   = lk_q.addr[addr_w-1 -: tag_w];

    assign cmp_set = cmp_q.addr[offset_bits +: set_bits];
    assign hit_any = |hit;
    assign cmp_hit = (state_q == st_lookup) && cmp_q.valid && hit_any;
    assign miss    = (state_q == st_lookup) && cmp_q.valid && !hit_any;

    // Miss raises busy in the compare cycle itself
    assign busy = (state_q != st_lookup) || miss || replay_q;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < ways; w++) begin
            if (hit[w]) begin
                hit_way = 2'(w);
            end
        end
    end

    //////////////////////////////
    // Refill and PLRU outputs
    //////////////////////////////

    assign mem_addr    = cmp_q.addr[addr_w-1:offset_bits];
    assign fill_we     = (state_q == st_fill_wait) && mem_rvalid;
    assign fill_last   = fill_we && (cnt_q == '1);
    assign fill_tag    = cmp_q.addr[addr_w-1 -: tag_w];
    assign fill.way    = fill_way_q;
    assign fill.set    = fill_set_w'(cmp_set);
    assign fill.offset = cnt_q;
    assign fill.data   = mem_rdata;

    assign touch     = cmp_hit || fill_last;
    assign touch_set = cmp_set;
    assign touch_way = fill_last ? fill_way_q : hit_way;

    //////////////////////////////
    // Pipeline and FSM
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= st_lookup;
            lk_q       <= '0;
            cmp_q      <= '0;
            cnt_q      <= '0;
            fill_way_q <= '0;
            replay_q   <= 1'b0;
            resp_valid <= 1'b0;
            mem_req    <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            mem_req    <= 1'b0;
            replay_q   <= 1'b0;
            unique case (state_q)
                st_lookup: begin
                    if (miss) begin
                        // Both stages hold until the refill is done
                        fill_way_q <= victim;
                        state_q    <= st_fill_req;
                    end else begin
                        resp_valid <= cmp_q.valid;
                        cmp_q      <= lk_q;
                        lk_q       <= '{valid: req, addr: req_addr};
                    end
                end
                st_fill_req: begin
                    mem_req <= 1'b1;
                    cnt_q   <= '0;
                    state_q <= st_fill_wait;
                end
                st_fill_wait: begin
                    if (mem_rvalid) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (cnt_q == '1) begin
                            state_q <= st_replay;
                        end
                    end
                end
                st_replay: begin
                    // Counter wrapped to 0 on the last fill word
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == 1) begin
                        resp_valid  <= 1'b1;
                        cmp_q.valid <= 1'b0;
                        if (!lk_q.valid) begin
                            state_q <= st_lookup;
                        end
                    end
                    if (cnt_q == 2) begin
                        // Stalled lookup re-enters compare
                        cmp_q      <= lk_q;
                        lk_q.valid <= 1'b0;
                        replay_q   <= 1'b1;
                        state_q    <= st_lookup;
                    end
                end
            endcase
        end
    end

    // Missed word and response payload
    always_ff @(posedge clk) begin
        if (fill_we && (cnt_q == cmp_q.addr[offset_bits-1:0])) begin
            miss_word_q <= mem_rdata;
        end
        if (state_q == st_lookup) begin
            resp <= '{data: rdata, hit: 1'b1};
        end else if (state_q == st_replay && cnt_q == 1) begin
            resp <= '{data: miss_word_q, hit: 1'b0};
        end
    end

endmodule

//--- source/l2c_replace.sv
`timescale 1ns/1ps

module l2c_replace #(
    parameter int set_bits = 4
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [set_bits-1:0]      set,
    input  logic [l2c_pkg::ways-1:0] valid,
    input  logic                     touch,
    input  logic [set_bits-1:0]      touch_set,
    input  logic [1:0]               touch_way,
    output logic [1:0]               victim
);

    import l2c_pkg::*;

    localparam int sets = 2**set_bits;

    // Bit 0 is the root, bit 1 covers ways 0/1, bit 2 covers ways 2/3
    logic [sets-1:0][2:0] plru_q;
    logic [2:0]           tree;
    logic [1:0]           tree_way;
    logic                 has_invalid;
    logic [1:0]           invalid_way;

    //////////////////////////////
    // Victim choice
    //////////////////////////////

    assign tree     = plru_q[set];
    assign tree_way = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};

    // Lowest invalid way wins
    always_comb begin
        has_invalid = 1'b0;
        invalid_way = '0;
        for (int w = ways - 1; w >= 0; w--) begin
            if (!valid[w]) begin
                has_invalid = 1'b1;
                invalid_way = 2'(w);
            end
        end
    end

    assign victim = has_invalid ? invalid_way : tree_way;

    //////////////////////////////
    // Tree update
    //////////////////////////////

    // Point both levels away from the touched way
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            plru_q <= '0;
        end else if (touch) begin
            plru_q[touch_set][0] <= ~touch_way[1];
            if (touch_way[1]) begin
                plru_q[touch_set][2] <= ~touch_way[0];
            end else begin
                plru_q[touch_set][1] <= ~touch_way[0];
            end
        end
    end

endmodule

//--- source/l2c_data_array.sv
`timescale 1ns/1ps

module l2c_data_array #(
    parameter int set_bits = 4
) (
    input  logic                            clk,
    input  logic [set_bits-1:0]             rd_set,
    input  logic [l2c_pkg::offset_bits-1:0] rd_offset,
    input  logic [l2c_pkg::ways-1:0]        hit,
    input  l2c_pkg::l2c_fill_t              fill,
    input  logic                            fill_we,
    output logic [l2c_pkg::word_w-1:0]      rdata
);

    import l2c_pkg::*;

    localparam int depth_bits = set_bits + offset_bits;

    logic [word_w-1:0]     word_rd [ways];
    logic [depth_bits-1:0] raddr;
    logic [depth_bits-1:0] waddr;

    // Word index inside the RAM is set then offset
    assign raddr = {rd_set, rd_offset};
    assign waddr = {fill.set[set_bits-1:0], fill.offset};

    for (genvar w = 0; w < ways; w++) begin : g_way
        l2c_bram #(
            .data_w     (word_w),
            .depth_bits (depth_bits)
        ) data_ram (
            .clk   (clk),
            .we    (fill_we && (fill.way == w)),
            .waddr (waddr),
            .din   (fill.data),
            .raddr (raddr),
            .dout  (word_rd[w])
        );
    end

    // At most one way hits, so an OR of the gated words is the mux
    always_comb begin
        rdata = '0;
        for (int w = 0; w < ways; w++) begin
            if (hit[w]) begin
                rdata = rdata | word_rd[w];
            end
        end
    end

endmodule

//--- source/l2c_tag_valid.sv
`timescale 1ns/1ps

module l2c_tag_valid #(
    parameter int set_bits = 4,
    localparam int tag_w = l2c_pkg::addr_w - l2c_pkg::offset_bits - set_bits
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [set_bits-1:0]      rd_set,
    input  logic [tag_w-1:0]         cmp_tag,
    input  l2c_pkg::l2c_fill_t       fill,
    input  logic                     fill_last,
    input  logic [tag_w-1:0]         fill_tag,
    output logic [l2c_pkg::ways-1:0] hit,
    output logic [l2c_pkg::ways-1:0] valid
);

    import l2c_pkg::*;

    localparam int sets = 2**set_bits;

    logic [ways-1:0][sets-1:0] valid_q;
    logic [set_bits-1:0]       set_q;
    logic [tag_w-1:0]          tag_q;
    logic [tag_w-1:0]          tag_rd [ways];
    logic [set_bits-1:0]       wr_set;

    // Upper bits of the fill set are unused at this size
    assign wr_set = fill.set[set_bits-1:0];

    //////////////////////////////
    // Valid bits
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            set_q   <= '0;
        end else begin
            set_q <= rd_set;
            if (fill_last) begin
                valid_q[fill.way][wr_set] <= 1'b1;
            end
        end
    end

    // Compare tag follows the RAM read by one cycle
    always_ff @(posedge clk) begin
        tag_q <= cmp_tag;
    end

    //////////////////////////////
    // Tag RAMs and hit vector
    //////////////////////////////

    for (genvar w = 0; w < ways; w++) begin : g_way
        l2c_bram #(
            .data_w     (tag_w),
            .depth_bits (set_bits)
        ) tag_ram (
            .clk   (clk),
            .we    (fill_last && (fill.way == w)),
            .waddr (wr_set),
            .din   (fill_tag),
            .raddr (rd_set),
            .dout  (tag_rd[w])
        );

        // Valid read at the same registered set as the tag
        assign valid[w] = valid_q[w][set_q];
        assign hit[w]   = valid[w] && (tag_rd[w] == tag_q);
    end

endmodule

//--- source/l2c_bram.sv
`timescale 1ns/1ps

module l2c_bram #(
    parameter int data_w     = 32,
    parameter int depth_bits = 4
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [depth_bits-1:0] waddr,
    input  logic [data_w-1:0]     din,
    input  logic [depth_bits-1:0] raddr,
    output logic [data_w-1:0]     dout
);

    logic [data_w-1:0] mem [2**depth_bits];

    // Registered read, old data on a same-address collision
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
        dout <= mem[raddr];
    end

endmodule

//--- source/l2c_pkg.sv
package l2c_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    // Data word and word address
    localparam int word_w = 32;
    localparam int addr_w = 16;

    // Associativity
    localparam int ways = 4;

    // Four words per line
    localparam int offset_bits = 2;

    // Widest set index a fill can carry
    localparam int fill_set_w = 8;

    //////////////////////////////
    // Pipeline and fill records
    //////////////////////////////

    // Request as held in the lookup and compare stages
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
    } l2c_req_t;

    // Returned word, hit clear when a refill was needed
    typedef struct packed {
        logic [word_w-1:0] data;
        logic              hit;
    } l2c_resp_t;

    // One refill word going into the arrays
    typedef struct packed {
        logic [1:0]             way;
        logic [fill_set_w-1:0]  set;
        logic [offset_bits-1:0] offset;
        logic [word_w-1:0]      data;
    } l2c_fill_t;

    //////////////////////////////
    // Controller states
    //////////////////////////////

    typedef enum logic [1:0] {
        st_lookup,
        st_fill_req,
        st_fill_wait,
        st_replay
    } l2c_state_e;

endpackage
